//--- filelist.f
logic/ppc_pkg.sv
logic/issue_if.sv
logic/wb_if.sv
logic/instruction_decode.sv
logic/gp_reg_file.sv
logic/fixed_point_unit.sv
logic/write_back_arbiter.sv
logic/ppc_core.sv
verif/ppc_core_tb.sv

//--- logic/fixed_point_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_point_unit #(
    parameter int                 RS_OFFSET = 0,
    parameter ppc_pkg::unit_sel_t UNIT = ppc_pkg::unit_add_sub
) (
    input  logic               clk,
    input  logic               rst_n,
    issue_if.unit              issue,
    wb_if.listener             wb,
    output logic               output_valid,
    input  logic               output_ready,
    output ppc_pkg::rs_id_t    output_rs_id,
    output ppc_pkg::reg_addr_t output_reg_addr,
    output ppc_pkg::word_t     output_result
);
    import ppc_pkg::*;

    rs_state_t state [RS_DEPTH];
    fxu_op_t   op [RS_DEPTH];
    operand_t  op1 [RS_DEPTH];
    operand_t  op2 [RS_DEPTH];
    operand_t  cap1 [RS_DEPTH];
    operand_t  cap2 [RS_DEPTH];
    reg_addr_t dest [RS_DEPTH];
    logic [RS_IDX_WIDTH-1:0] free_idx;
    logic [RS_IDX_WIDTH-1:0] sel_idx;
    logic      issue_fire;
    logic      retire;
    word_t     a;
    word_t     b;

    // Downward scan, so the lowest index wins
    always_comb begin
        issue.ready = 1'b0;
        free_idx = '0;
        output_valid = 1'b0;
        sel_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            cap1[i] = capture_operand(op1[i], wb.valid, wb.rs_id, wb.result);
            cap2[i] = capture_operand(op2[i], wb.valid, wb.rs_id, wb.result);
            if (state[i] == rs_free) begin
                issue.ready = 1'b1;
                free_idx = RS_IDX_WIDTH'(i);
            end
            if (state[i] == rs_ready) begin
                output_valid = 1'b1;
                sel_idx = RS_IDX_WIDTH'(i);
            end
        end
    end

    assign issue.id_free = rs_id_t'(RS_OFFSET + free_idx);
    assign issue_fire = issue.valid && issue.ready;
    assign retire = output_valid && output_ready;

    assign output_rs_id = rs_id_t'(RS_OFFSET + sel_idx);
    assign output_reg_addr = dest[sel_idx];
    assign a = op1[sel_idx].value;
    assign b = op2[sel_idx].value;

    always_comb begin
        if (UNIT == unit_add_sub) begin
            // subf computes RB - RA
            output_result = (op[sel_idx] == fxu_subf) ? b - a : a + b;
        end else begin
            case (op[sel_idx])
                fxu_and: output_result = a & b;
                fxu_or:  output_result = a | b;
                default: output_result = a ^ b;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state[i] <= rs_free;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                case (state[i])
                    rs_free: begin
                        if (issue_fire && free_idx == i) begin
                            state[i] <= (issue.op1.valid && issue.op2.valid) ? rs_ready
                                                                             : rs_wait;
                        end
                    end
                    rs_wait: begin
                        if (cap1[i].valid && cap2[i].valid) begin
                            state[i] <= rs_ready;
                        end
                    end
                    default: begin
                        if (retire && sel_idx == i) begin
                            state[i] <= rs_free;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (issue_fire && free_idx == i) begin
                op[i] <= issue.op;
                op1[i] <= issue.op1;
                op2[i] <= issue.op2;
                dest[i] <= issue.result_reg_addr;
            end else begin
                op1[i] <= cap1[i];
                op2[i] <= cap2[i];
            end
        end
    end

    issue_to_free_entry: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire |-> state[free_idx] == rs_free);

endmodule

`default_nettype wire

//--- logic/gp_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module gp_reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  ppc_pkg::reg_addr_t read_addr [2],
    output ppc_pkg::operand_t  read_operand [2],
    input  ppc_pkg::reg_addr_t update_addr,
    input  logic               update_enable,
    input  ppc_pkg::rs_id_t    update_rs_id,
    wb_if.listener             wb
);
    import ppc_pkg::*;

    word_t  value [32];
    logic   valid [32];
    rs_id_t tag [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                value[i] <= '0;
                valid[i] <= 1'b1;
                tag[i] <= '0;
            end
        end else begin
            // Only the youngest producer may write
            if (wb.valid && !valid[wb.reg_addr] && tag[wb.reg_addr] == wb.rs_id) begin
                value[wb.reg_addr] <= wb.result;
                valid[wb.reg_addr] <= 1'b1;
            end
            if (update_enable) begin
                valid[update_addr] <= 1'b0;
                tag[update_addr] <= update_rs_id;
            end
        end
    end

    // Reads see this cycle's write-back
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            read_operand[p] = capture_operand('{value: value[read_addr[p]],
                                                valid: valid[read_addr[p]],
                                                rs_id: tag[read_addr[p]]},
                                              wb.valid, wb.rs_id, wb.result);
        end
    end

endmodule

`default_nettype wire

//--- logic/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instruction_valid,
    output logic               instruction_ready,
    input  ppc_pkg::word_t     instruction,
    output ppc_pkg::reg_addr_t read_addr [2],
    input  ppc_pkg::operand_t  read_operand [2],
    output ppc_pkg::reg_addr_t update_addr,
    output logic               update_enable,
    output ppc_pkg::rs_id_t    update_rs_id,
    issue_if.dispatch          add_sub_issue,
    issue_if.dispatch          log_issue,
    wb_if.listener             wb
);
    import ppc_pkg::*;

    decode_t  decoded;
    decode_t  stage;
    logic     stage_valid;
    operand_t stage_op1;
    operand_t stage_op2;
    operand_t cur_op1;
    operand_t cur_op2;
    operand_t new_op1;
    operand_t new_op2;
    logic     issue_fire;
    logic     discard;
    logic     accept;
    rs_id_t   issue_rs_id;

    always_comb begin
        decoded = '0;
        decoded.unit_sel = unit_none;
        decoded.rt = instruction[6:10];
        decoded.ra = instruction[11:15];
        decoded.rb = instruction[16:20];
        case (instruction[0:5])
            opc_addi: begin
                decoded.unit_sel = unit_add_sub;
                decoded.op = fxu_add;
                decoded.use_imm = 1'b1;
                decoded.zero_op1 = (instruction[11:15] == 5'd0);
                decoded.imm = {{16{instruction[16]}}, instruction[16:31]};
            end
            opc_ori, opc_xori: begin
                decoded.unit_sel = unit_log;
                decoded.op = (instruction[0:5] == opc_ori) ? fxu_or : fxu_xor;
                decoded.use_imm = 1'b1;
                decoded.imm = {16'h0000, instruction[16:31]};
            end
            opc_ext: begin
                // Record forms are not supported
                if (!instruction[31]) begin
                    case (instruction[21:30])
                        xo_add:  {decoded.unit_sel, decoded.op} = {unit_add_sub, fxu_add};
                        xo_subf: {decoded.unit_sel, decoded.op} = {unit_add_sub, fxu_subf};
                        xo_and:  {decoded.unit_sel, decoded.op} = {unit_log, fxu_and};
                        xo_or:   {decoded.unit_sel, decoded.op} = {unit_log, fxu_or};
                        xo_xor:  {decoded.unit_sel, decoded.op} = {unit_log, fxu_xor};
                        default: decoded.unit_sel = unit_none;
                    endcase
                end
            end
            default: decoded.unit_sel = unit_none;
        endcase
        // Logical ops take RS in bits 6-10 and write RA
        if (decoded.unit_sel == unit_log) begin
            decoded.rt = instruction[11:15];
            decoded.ra = instruction[6:10];
        end
    end

    assign issue_rs_id = (stage.unit_sel == unit_log) ? log_issue.id_free
                                                      : add_sub_issue.id_free;
    assign issue_fire = stage_valid &&
                        ((stage.unit_sel == unit_add_sub && add_sub_issue.ready) ||
                         (stage.unit_sel == unit_log && log_issue.ready));
    assign discard = stage_valid && stage.unit_sel == unit_none;
    assign instruction_ready = !stage_valid || issue_fire || discard;
    assign accept = instruction_valid && instruction_ready;

    assign read_addr[0] = decoded.ra;
    assign read_addr[1] = decoded.rb;

    assign cur_op1 = capture_operand(stage_op1, wb.valid, wb.rs_id, wb.result);
    assign cur_op2 = capture_operand(stage_op2, wb.valid, wb.rs_id, wb.result);

    always_comb begin
        new_op1 = read_operand[0];
        new_op2 = read_operand[1];
        // Tag update of the leaving instruction is not yet in the GPRs
        if (issue_fire && stage.rt == decoded.ra) begin
            new_op1 = '{value: '0, valid: 1'b0, rs_id: issue_rs_id};
        end
        if (issue_fire && stage.rt == decoded.rb) begin
            new_op2 = '{value: '0, valid: 1'b0, rs_id: issue_rs_id};
        end
        if (decoded.zero_op1) begin
            new_op1 = '{value: '0, valid: 1'b1, rs_id: '0};
        end
        if (decoded.use_imm) begin
            new_op2 = '{value: decoded.imm, valid: 1'b1, rs_id: '0};
        end
    end

    assign add_sub_issue.valid = stage_valid && stage.unit_sel == unit_add_sub;
    assign add_sub_issue.op = stage.op;
    assign add_sub_issue.op1 = cur_op1;
    assign add_sub_issue.op2 = cur_op2;
    assign add_sub_issue.result_reg_addr = stage.rt;

    assign log_issue.valid = stage_valid && stage.unit_sel == unit_log;
    assign log_issue.op = stage.op;
    assign log_issue.op1 = cur_op1;
    assign log_issue.op2 = cur_op2;
    assign log_issue.result_reg_addr = stage.rt;

    assign update_addr = stage.rt;
    assign update_enable = issue_fire;
    assign update_rs_id = issue_rs_id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else if (accept) begin
            stage_valid <= 1'b1;
        end else if (issue_fire || discard) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage <= decoded;
            stage_op1 <= new_op1;
            stage_op2 <= new_op2;
        end else begin
            stage_op1 <= cur_op1;
            stage_op2 <= cur_op2;
        end
    end

    single_issue: assert property (@(posedge clk) disable iff (!rst_n)
        !(add_sub_issue.valid && log_issue.valid));

endmodule

`default_nettype wire

//--- logic/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
    import ppc_pkg::*;

    logic      valid;
    logic      ready;
    fxu_op_t   op;
    operand_t  op1;
    operand_t  op2;
    reg_addr_t result_reg_addr;
    rs_id_t    id_free;

    modport dispatch (
        output valid,
        output op,
        output op1,
        output op2,
        output result_reg_addr,
        input  ready,
        input  id_free
    );

    modport unit (
        input  valid,
        input  op,
        input  op1,
        input  op2,
        input  result_reg_addr,
        output ready,
        output id_free
    );

endinterface

`default_nettype wire

//--- logic/ppc_core.sv
`timescale 1ns/1ps
`default_nettype none

module ppc_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instruction_valid,
    output logic               instruction_ready,
    input  ppc_pkg::word_t     instruction,
    output logic               result_valid,
    output ppc_pkg::rs_id_t    result_rs_id,
    output ppc_pkg::reg_addr_t result_reg_addr,
    output ppc_pkg::word_t     result
);
    import ppc_pkg::*;

    reg_addr_t gpr_read_addr [2];
    operand_t  gpr_read_operand [2];
    reg_addr_t gpr_update_addr;
    logic      gpr_update_enable;
    rs_id_t    gpr_update_rs_id;

    // Arbiter port 0 is add/sub, port 1 is logical
    logic      fxu_valid [ARB_PORTS];
    logic      fxu_ready [ARB_PORTS];
    rs_id_t    fxu_rs_id [ARB_PORTS];
    reg_addr_t fxu_reg_addr [ARB_PORTS];
    word_t     fxu_result [ARB_PORTS];

    issue_if add_sub_issue ();
    issue_if log_issue ();
    wb_if    wb ();

    instruction_decode decode (
        .clk               (clk),
        .rst_n             (rst_n),
        .instruction_valid (instruction_valid),
        .instruction_ready (instruction_ready),
        .instruction       (instruction),
        .read_addr         (gpr_read_addr),
        .read_operand      (gpr_read_operand),
        .update_addr       (gpr_update_addr),
        .update_enable     (gpr_update_enable),
        .update_rs_id      (gpr_update_rs_id),
        .add_sub_issue     (add_sub_issue.dispatch),
        .log_issue         (log_issue.dispatch),
        .wb                (wb.listener)
    );

    gp_reg_file gprs (
        .clk           (clk),
        .rst_n         (rst_n),
        .read_addr     (gpr_read_addr),
        .read_operand  (gpr_read_operand),
        .update_addr   (gpr_update_addr),
        .update_enable (gpr_update_enable),
        .update_rs_id  (gpr_update_rs_id),
        .wb            (wb.listener)
    );

    fixed_point_unit #(
        .RS_OFFSET (ADD_SUB_RS_OFFSET),
        .UNIT      (unit_add_sub)
    ) add_sub_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .issue           (add_sub_issue.unit),
        .wb              (wb.listener),
        .output_valid    (fxu_valid[0]),
        .output_ready    (fxu_ready[0]),
        .output_rs_id    (fxu_rs_id[0]),
        .output_reg_addr (fxu_reg_addr[0]),
        .output_result   (fxu_result[0])
    );

    fixed_point_unit #(
        .RS_OFFSET (LOG_RS_OFFSET),
        .UNIT      (unit_log)
    ) log_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .issue           (log_issue.unit),
        .wb              (wb.listener),
        .output_valid    (fxu_valid[1]),
        .output_ready    (fxu_ready[1]),
        .output_rs_id    (fxu_rs_id[1]),
        .output_reg_addr (fxu_reg_addr[1]),
        .output_result   (fxu_result[1])
    );

    write_back_arbiter arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (fxu_valid),
        .in_ready    (fxu_ready),
        .in_rs_id    (fxu_rs_id),
        .in_reg_addr (fxu_reg_addr),
        .in_result   (fxu_result),
        .wb          (wb.source)
    );

    assign result_valid = wb.valid;
    assign result_rs_id = wb.rs_id;
    assign result_reg_addr = wb.reg_addr;
    assign result = wb.result;

endmodule

`default_nettype wire

//--- logic/ppc_pkg.sv
`default_nettype none

package ppc_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int RS_DEPTH = 8;
    localparam int RS_IDX_WIDTH = $clog2(RS_DEPTH);
    localparam int RS_ID_WIDTH = 4;
    localparam int ADD_SUB_RS_OFFSET = 0;
    localparam int LOG_RS_OFFSET = 8;
    localparam int ARB_PORTS = 2;
    localparam int ARB_IDX_WIDTH = $clog2(ARB_PORTS);

    // Bit 0 is the MSB, as in the architecture manual
    typedef logic [0:WORD_WIDTH-1] word_t;
    typedef logic [0:REG_ADDR_WIDTH-1] reg_addr_t;
    typedef logic [0:RS_ID_WIDTH-1] rs_id_t;

    typedef enum logic [2:0] {fxu_add, fxu_subf, fxu_and, fxu_or, fxu_xor} fxu_op_t;

    typedef enum logic [1:0] {unit_add_sub, unit_log, unit_none} unit_sel_t;

    typedef enum logic [1:0] {rs_free, rs_wait, rs_ready} rs_state_t;

    // Primary opcodes, instruction bits 0 to 5
    typedef enum logic [5:0] {
        opc_addi = 6'd14,
        opc_ori  = 6'd24,
        opc_xori = 6'd26,
        opc_ext  = 6'd31
    } opcode_t;

    // Extended opcodes of primary 31, bits 21 to 30 with OE clear
    typedef enum logic [9:0] {
        xo_and  = 10'd28,
        xo_subf = 10'd40,
        xo_add  = 10'd266,
        xo_xor  = 10'd316,
        xo_or   = 10'd444
    } ext_opcode_t;

    typedef struct packed {
        word_t  value;
        logic   valid;
        rs_id_t rs_id;
    } operand_t;

    typedef struct packed {
        unit_sel_t unit_sel;
        fxu_op_t   op;
        reg_addr_t ra;
        reg_addr_t rb;
        reg_addr_t rt;
        logic      use_imm;
        logic      zero_op1;
        word_t     imm;
    } decode_t;

    // Snoop the write-back bus for a pending operand
    function automatic operand_t capture_operand(operand_t op, logic wb_valid,
                                                 rs_id_t wb_rs_id, word_t wb_result);
        operand_t captured;
        captured = op;
        if (!op.valid && wb_valid && op.rs_id == wb_rs_id) begin
            captured.value = wb_result;
            captured.valid = 1'b1;
        end
        return captured;
    endfunction

endpackage

`default_nettype wire

//--- logic/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
    import ppc_pkg::*;

    logic      valid;
    rs_id_t    rs_id;
    reg_addr_t reg_addr;
    word_t     result;

    modport source (output valid, output rs_id, output reg_addr, output result);

    modport listener (input valid, input rs_id, input reg_addr, input result);

endinterface

`default_nettype wire

//--- logic/write_back_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_back_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid [ppc_pkg::ARB_PORTS],
    output logic               in_ready [ppc_pkg::ARB_PORTS],
    input  ppc_pkg::rs_id_t    in_rs_id [ppc_pkg::ARB_PORTS],
    input  ppc_pkg::reg_addr_t in_reg_addr [ppc_pkg::ARB_PORTS],
    input  ppc_pkg::word_t     in_result [ppc_pkg::ARB_PORTS],
    wb_if.source               wb
);
    import ppc_pkg::*;

    logic [ARB_IDX_WIDTH-1:0] rr_ptr;
    logic [ARB_IDX_WIDTH-1:0] grant_idx;
    logic [ARB_PORTS-1:0]     grant;

    // First valid port at or after the pointer
    always_comb begin
        int port;
        grant = '0;
        grant_idx = '0;
        for (int k = ARB_PORTS - 1; k >= 0; k--) begin
            port = (int'(rr_ptr) + k) % ARB_PORTS;
            if (in_valid[port]) begin
                grant = '0;
                grant[port] = 1'b1;
                grant_idx = ARB_IDX_WIDTH'(port);
            end
        end
        for (int p = 0; p < ARB_PORTS; p++) begin
            in_ready[p] = grant[p];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= |grant;
            if (|grant) begin
                rr_ptr <= (grant_idx == ARB_IDX_WIDTH'(ARB_PORTS - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            wb.rs_id <= in_rs_id[grant_idx];
            wb.reg_addr <= in_reg_addr[grant_idx];
            wb.result <= in_result[grant_idx];
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant));

endmodule

`default_nettype wire

//--- verif/ppc_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ppc_core_tb;

    localparam int CLK_PERIOD_NS = 4;
    localparam int DRIVE_DELAY_NS = 1;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLES_PER_LINE = 40;
    localparam int DRAIN_CYCLES = 20;
    localparam logic [31:0] LFSR_SEED = 32'h14a9_2b6e;
    localparam logic [31:0] LFSR_TAPS = 32'ha300_0000;
    localparam logic [3:0] LOG_RS_FIRST = 4'd8;
    localparam string VECTOR_FILE = "verif/ppc_core_vectors.txt";

    logic        clk;
    logic        rst_n;
    logic        instruction_valid;
    logic        instruction_ready;
    logic [31:0] instruction;
    logic        result_valid;
    logic [3:0]  result_rs_id;
    logic [4:0]  result_reg_addr;
    logic [31:0] result;

    // In-order reference state
    logic [31:0] model_gpr [32];
    logic [31:0] instr_queue [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_value [$];
    logic        exp_logical [$];
    logic        exp_matched [$];
    int          matched_count;
    int          vector_lines;
    int          stall_cycles;
    logic        vectors_loaded;
    logic [31:0] lfsr;

    ppc_core ppc_core_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .instruction_valid (instruction_valid),
        .instruction_ready (instruction_ready),
        .instruction       (instruction),
        .result_valid      (result_valid),
        .result_rs_id      (result_rs_id),
        .result_reg_addr   (result_reg_addr),
        .result            (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // PowerPC semantics of the kept subset, executed in program order
    task automatic execute_model(input logic [31:0] word, output logic writes,
                                 output logic [4:0] dest, output logic [31:0] value,
                                 output logic logical);
        logic [5:0]  opcode;
        logic [4:0]  rt_field;
        logic [4:0]  ra_field;
        logic [4:0]  rb_field;
        logic [9:0]  xo;
        logic [15:0] imm;
        opcode = word[31:26];
        rt_field = word[25:21];
        ra_field = word[20:16];
        rb_field = word[15:11];
        xo = word[10:1];
        imm = word[15:0];
        writes = 1'b1;
        dest = rt_field;
        value = '0;
        logical = 1'b0;
        case (opcode)
            6'd14: begin
                value = ((ra_field == 5'd0) ? 32'h0 : model_gpr[ra_field])
                        + {{16{imm[15]}}, imm};
            end
            6'd24: begin
                dest = ra_field;
                logical = 1'b1;
                value = model_gpr[rt_field] | {16'h0000, imm};
            end
            6'd26: begin
                dest = ra_field;
                logical = 1'b1;
                value = model_gpr[rt_field] ^ {16'h0000, imm};
            end
            6'd31: begin
                // Rc set means a record form, which the core drops
                if (word[0]) begin
                    writes = 1'b0;
                end else begin
                    case (xo)
                        10'd266: value = model_gpr[ra_field] + model_gpr[rb_field];
                        10'd40:  value = model_gpr[rb_field] - model_gpr[ra_field];
                        10'd28: begin
                            dest = ra_field;
                            logical = 1'b1;
                            value = model_gpr[rt_field] & model_gpr[rb_field];
                        end
                        10'd444: begin
                            dest = ra_field;
                            logical = 1'b1;
                            value = model_gpr[rt_field] | model_gpr[rb_field];
                        end
                        10'd316: begin
                            dest = ra_field;
                            logical = 1'b1;
                            value = model_gpr[rt_field] ^ model_gpr[rb_field];
                        end
                        default: writes = 1'b0;
                    endcase
                end
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            model_gpr[dest] = value;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        int          ch;
        logic [7:0]  kind;
        logic [31:0] word;
        logic [31:0] reg_field;
        logic [31:0] value;
        logic        pending;
        logic        writes;
        logic [4:0]  dest;
        logic [31:0] model_value;
        logic        is_logical;
        pending = 1'b0;
        writes = 1'b0;
        dest = '0;
        model_value = '0;
        is_logical = 1'b0;
        foreach (model_gpr[r]) begin
            model_gpr[r] = '0;
        end
        fd = $fopen(VECTOR_FILE, "r");
        assert (fd != 0) else fail_run("cannot open the vector file");
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1) begin
                case (kind)
                    "#": begin
                        ch = 0;
                        while (ch != "\n" && ch != -1) begin
                            ch = $fgetc(fd);
                        end
                    end
                    "I": begin
                        code = $fscanf(fd, "%h", word);
                        assert (code == 1) else fail_run("vector file has a broken I line");
                        assert (!pending)
                        else fail_run("vector file has an instruction with no expected line");
                        execute_model(word, writes, dest, model_value, is_logical);
                        instr_queue.push_back(word);
                        pending = writes;
                        vector_lines++;
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h", reg_field, value);
                        assert (code == 2) else fail_run("vector file has a broken E line");
                        assert (pending)
                        else fail_run("vector file expects a result that no instruction makes");
                        assert (reg_field[4:0] == dest && value == model_value)
                        else fail_run($sformatf(
                            "mismatch vector expected: reg_addr=%h value=%h model %h %h",
                            reg_field[4:0], value, dest, model_value));
                        exp_reg.push_back(dest);
                        exp_value.push_back(model_value);
                        exp_logical.push_back(is_logical);
                        exp_matched.push_back(1'b0);
                        pending = 1'b0;
                        vector_lines++;
                    end
                    default: fail_run("vector file has a line of unknown kind");
                endcase
            end
        end
        assert (!pending) else fail_run("vector file ends without the last expected line");
        $fclose(fd);
    endtask

    // Any unmatched entry with the same register and value will do
    task automatic match_result(input logic [3:0] rs_id, input logic [4:0] reg_addr,
                                input logic [31:0] value);
        int found = -1;
        foreach (exp_reg[i]) begin
            if (found < 0 && !exp_matched[i] && exp_reg[i] == reg_addr
                    && exp_value[i] == value) begin
                found = i;
            end
        end
        assert (found >= 0)
        else fail_run($sformatf("mismatch result: reg_addr=%h value=%h has no expected entry",
                                reg_addr, value));
        // Logical unit owns the upper block of station IDs
        assert ((rs_id >= LOG_RS_FIRST) == exp_logical[found])
        else fail_run($sformatf("mismatch result_rs_id: rs_id=%h reg_addr=%h value=%h",
                                rs_id, reg_addr, value));
        exp_matched[found] = 1'b1;
        matched_count++;
    endtask

    task automatic send_instruction(input logic [31:0] word);
        instruction = word;
        instruction_valid = 1'b1;
        @(negedge clk);
        while (!instruction_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY_NS;
        instruction_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (result_valid) begin
                match_result(result_rs_id, result_reg_addr, result);
            end
            if (instruction_valid && !instruction_ready) begin
                stall_cycles++;
            end
        end
    end

    initial begin : watchdog
        int limit_ns;
        wait (vectors_loaded === 1'b1);
        limit_ns = (vector_lines * CYCLES_PER_LINE + RESET_CYCLES + DRAIN_CYCLES)
                   * CLK_PERIOD_NS;
        #(limit_ns);
        fail_run("timeout: not all results written back");
    end

    initial begin : stimulus
        logic [1:0] gap;
        rst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction = '0;
        matched_count = 0;
        vector_lines = 0;
        stall_cycles = 0;
        vectors_loaded = 1'b0;
        lfsr = LFSR_SEED;
        load_vectors();
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY_NS;
        rst_n = 1'b1;
        @(negedge clk);
        assert (instruction_ready === 1'b1 && result_valid === 1'b0)
        else fail_run($sformatf("mismatch after reset: instruction_ready=%h result_valid=%h",
                                instruction_ready, result_valid));
        @(posedge clk);
        #DRIVE_DELAY_NS;

        foreach (instr_queue[n]) begin
            lfsr = galois_step(lfsr);
            gap[0] = lfsr[0];
            lfsr = galois_step(lfsr);
            gap[1] = lfsr[0];
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY_NS;
            end
            send_instruction(instr_queue[n]);
        end

        wait (matched_count == exp_reg.size());
        // Late stray write-backs would still hit the scoreboard here
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("info: %0d instructions, %0d results, %0d stall cycles",
                 instr_queue.size(), matched_count, stall_cycles);
        if (matched_count == exp_reg.size()) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("expected results left unmatched at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- verif/ppc_core_vectors.txt
# I <instruction word, hex>
# E <destination GPR, hex> <value written back, hex>
I 38200010
E 01 00000010
I 38410025
E 02 00000035
I 7c611214
E 03 00000045
I 7c831a14
E 04 0000008a
I 7ca12050
E 05 0000007a
I 38c0ffff
E 06 ffffffff
I 68c78001
E 07 ffff7ffe
I 60288000
E 08 00008010
I 7ce92838
E 09 0000007a
I 7c6a4378
E 0a 00008055
I 7d4b3a78
E 0b ffffffab
# r0 gets a value, then addi with RA=0 must still read zero
I 38010001
E 00 00000011
I 39800005
E 0c 00000005
I 7da06214
E 0d 00000016
# Two writes to r14 in flight
I 39cb0001
E 0e ffffffac
I 39ce0100
E 0e 000000ac
I 7dee6850
E 0f ffffff6a
# mulli and add. are discarded
I 1e010003
I 7e011215
# Dependent add chain on r16
I 7e100a14
E 10 00000010
I 7e100a14
E 10 00000020
I 7e100a14
E 10 00000030
I 7e100a14
E 10 00000040
I 7e100a14
E 10 00000050
I 7e100a14
E 10 00000060
I 7e100a14
E 10 00000070
I 7e100a14
E 10 00000080
I 7e100a14
E 10 00000090
I 7e100a14
E 10 000000a0
I 6a11ffff
E 11 0000ff5f
